/* src/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // ====================
  // serial timing
  // ====================

  localparam int CLKS_PER_BIT = 16;             // kept short for simulation
  localparam int FRAME_BITS   = 11;             // start, 8 data, parity, stop
  localparam int GAP_CYCLES   = 20;             // idle tx cycles between the two request frames
  localparam int RESP_TIMEOUT = 400;            // wait for a reply start bit

  localparam int HALF_BIT  = CLKS_PER_BIT / 2;
  localparam int PAR_IDX   = FRAME_BITS - 2;    // bit index of the parity bit in a frame
  localparam int STOP_IDX  = FRAME_BITS - 1;

  localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_IDX_W = $clog2(FRAME_BITS);
  localparam int GAP_CNT_W = $clog2(GAP_CYCLES);
  localparam int TO_CNT_W  = $clog2(RESP_TIMEOUT);

  // ====================
  // sequencer states
  // ====================

  localparam int ST_W = 3;

  localparam logic [ST_W-1:0] ST_IDLE    = 3'd0;
  localparam logic [ST_W-1:0] ST_SEND_HI = 3'd1;
  localparam logic [ST_W-1:0] ST_GAP     = 3'd2;
  localparam logic [ST_W-1:0] ST_SEND_LO = 3'd3;
  localparam logic [ST_W-1:0] ST_WAIT    = 3'd4;
  localparam logic [ST_W-1:0] ST_REPORT  = 3'd5;

  // ====================
  // command and result types
  // ====================

  typedef struct packed {
    logic       write;                          // 1 = write, 0 = read
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_fields_t;

  typedef struct packed {
    logic [7:0] hi;                             // goes out in the first frame
    logic [7:0] lo;
  } cmd_bytes_t;

  typedef union packed {
    cmd_fields_t fields;
    cmd_bytes_t  bytes;
  } cmd_word_t;

  typedef struct packed {
    logic [7:0] data;
    logic       parity_ok;
    logic       stop_ok;
  } rx_frame_t;

  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       framing_err;
    logic       timeout;
  } rd_result_t;

endpackage

/* src/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic [7:0] data,
  output logic       tx,
  output logic       done
);

  import uart_cmd_pkg::*;

  logic                  busy;
  logic [BIT_CNT_W-1:0]  clk_cnt;
  logic [BIT_IDX_W-1:0]  bit_idx;
  logic [FRAME_BITS-2:0] shift_q;              // bits still to go after the start bit
  logic                  bit_end;
  logic                  last_bit;

  assign bit_end  = busy && (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
  assign last_bit = (bit_idx == BIT_IDX_W'(STOP_IDX));
  assign done     = bit_end && last_bit;       // last cycle of the stop bit

  // ====================
  // bit timing and line driver
  // ====================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      tx      <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
    end
    else if (!busy)
    begin
      clk_cnt <= '0;
      bit_idx <= '0;
      if (start)
      begin
        busy <= 1'b1;
        tx   <= 1'b0;                          // start bit begins next cycle
      end
    end
    else if (bit_end)
    begin
      clk_cnt <= '0;
      if (last_bit)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        tx      <= shift_q[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end
    else
    begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // odd parity, so data plus parity holds an odd number of ones
  always_ff @(posedge clk)
  begin
    if (!busy && start)
      shift_q <= {1'b1, ~^data, data};
    else if (bit_end && !last_bit)
      shift_q <= {1'b1, shift_q[FRAME_BITS-2:1]};
  end

endmodule

/* src/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  input  logic                    en,
  output logic                    frame_vld,
  output uart_cmd_pkg::rx_frame_t frame,
  output logic                    busy
);

  import uart_cmd_pkg::*;

  logic [2:0]           rx_sr;                 // two sync flops plus one cycle of history
  logic                 rx_s;
  logic                 fall;
  logic [BIT_CNT_W-1:0] clk_cnt;
  logic [BIT_IDX_W-1:0] bit_idx;
  logic [7:0]           data_sr;
  logic                 par_bit;
  logic                 sample;

  assign rx_s   = rx_sr[1];
  assign fall   = rx_sr[2] & ~rx_sr[1];
  assign sample = busy && (clk_cnt == BIT_CNT_W'(HALF_BIT));  // mid-bit

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rx_sr <= '1;                             // line idles high
    else
      rx_sr <= {rx_sr[1:0], rx};
  end

  // ====================
  // frame control
  // ====================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy      <= 1'b0;
      frame_vld <= 1'b0;
      clk_cnt   <= '0;
      bit_idx   <= '0;
    end
    else
    begin
      frame_vld <= 1'b0;
      if (!busy)
      begin
        if (en && fall)
        begin
          busy    <= 1'b1;
          clk_cnt <= BIT_CNT_W'(1);            // the edge cycle counts as cycle 0
          bit_idx <= '0;
        end
      end
      else
      begin
        if (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1))
          clk_cnt <= '0;
        else
          clk_cnt <= clk_cnt + 1'b1;
        if (sample)
        begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == '0 && rx_s)
            busy <= 1'b0;                      // start bit gone by mid-bit, treat as a glitch
          else if (bit_idx == BIT_IDX_W'(STOP_IDX))
          begin
            busy      <= 1'b0;
            frame_vld <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx == BIT_IDX_W'(PAR_IDX))
        par_bit <= rx_s;
      else if (bit_idx == BIT_IDX_W'(STOP_IDX))
      begin
        frame.data      <= data_sr;
        frame.parity_ok <= ^{data_sr, par_bit};
        frame.stop_ok   <= rx_s;
      end
      else if (bit_idx != '0)
        data_sr <= {rx_s, data_sr[7:1]};       // LSB arrives first
    end
  end

endmodule

/* src/uart_cmd_master.sv */
`timescale 1ns/1ps

module uart_cmd_master (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cmd_vld,
  input  uart_cmd_pkg::cmd_word_t  cmd,
  input  logic                     tx_done,
  input  logic                     rx_vld,
  input  uart_cmd_pkg::rx_frame_t  rx_frame,
  input  logic                     rx_busy,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output logic [7:0]               tx_byte,
  output logic                     rx_en,
  output logic                     rd_vld,
  output uart_cmd_pkg::rd_result_t rd_result
);

  import uart_cmd_pkg::*;

  logic [ST_W-1:0]      state_q;
  logic [ST_W-1:0]      state_d;
  cmd_word_t            cmd_q;
  logic [GAP_CNT_W-1:0] gap_cnt;
  logic [TO_CNT_W-1:0]  to_cnt;
  rd_result_t           result_q;
  logic                 accept;
  logic                 gap_end;
  logic                 timeout_hit;

  // ====================
  // host and link outputs
  // ====================

  assign cmd_rdy     = (state_q == ST_IDLE);
  assign accept      = cmd_rdy && cmd_vld;
  assign gap_end     = (state_q == ST_GAP) && (gap_cnt == GAP_CNT_W'(GAP_CYCLES - 1));
  assign timeout_hit = (state_q == ST_WAIT) && !rx_busy
                       && (to_cnt == TO_CNT_W'(RESP_TIMEOUT - 1));

  // first frame starts straight from the host word so tx moves the cycle after accept
  assign tx_start = accept || gap_end;
  assign tx_byte  = (state_q == ST_IDLE) ? cmd.bytes.hi : cmd_q.bytes.lo;

  assign rx_en     = (state_q == ST_WAIT);
  assign rd_vld    = (state_q == ST_REPORT);
  assign rd_result = result_q;

  // ====================
  // sequencer
  // ====================

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (accept)
          state_d = ST_SEND_HI;
      ST_SEND_HI:
        if (tx_done)
          state_d = ST_GAP;
      ST_GAP:
        if (gap_end)
          state_d = ST_SEND_LO;
      ST_SEND_LO:
        if (tx_done)
          state_d = cmd_q.fields.write ? ST_IDLE : ST_WAIT;
      ST_WAIT:
        if (rx_vld || timeout_hit)
          state_d = ST_REPORT;
      ST_REPORT:
        state_d = ST_IDLE;
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= ST_IDLE;
      gap_cnt <= '0;
      to_cnt  <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == ST_GAP)
        gap_cnt <= gap_cnt + 1'b1;
      else
        gap_cnt <= '0;
      if (state_q != ST_WAIT)
        to_cnt <= '0;
      else if (!rx_busy)
        to_cnt <= to_cnt + 1'b1;               // holds once the reply has started
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd;
    if (state_q == ST_WAIT)
    begin
      if (rx_vld)
      begin
        result_q.data        <= rx_frame.data;
        result_q.parity_err  <= ~rx_frame.parity_ok;
        result_q.framing_err <= ~rx_frame.stop_ok;
        result_q.timeout     <= 1'b0;
      end
      else if (timeout_hit)
      begin
        result_q <= '{data: 8'h00, parity_err: 1'b0, framing_err: 1'b0, timeout: 1'b1};
      end
    end
  end

endmodule

/* src/uart_cmd_top.sv */
`timescale 1ns/1ps

module uart_cmd_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cmd_vld,
  input  uart_cmd_pkg::cmd_word_t  cmd,
  input  logic                     rx,
  output logic                     tx,
  output logic                     cmd_rdy,
  output logic                     rd_vld,
  output uart_cmd_pkg::rd_result_t rd_result
);

  import uart_cmd_pkg::*;

  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_done;
  logic       rx_en;
  logic       rx_vld;
  logic       rx_busy;
  rx_frame_t  rx_frame;

  uart_cmd_master master_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .cmd       (cmd),
    .tx_done   (tx_done),
    .rx_vld    (rx_vld),
    .rx_frame  (rx_frame),
    .rx_busy   (rx_busy),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .rx_en     (rx_en),
    .rd_vld    (rd_vld),
    .rd_result (rd_result)
  );

  uart_tx tx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tx_start),
    .data  (tx_byte),
    .tx    (tx),
    .done  (tx_done)
  );

  uart_rx rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .en        (rx_en),
    .frame_vld (rx_vld),
    .frame     (rx_frame),
    .busy      (rx_busy)
  );

endmodule

/* verif/uart_cmd_properties.sv */
`timescale 1ns/1ps

module uart_cmd_properties (
  input logic clk,
  input logic rst_n,
  input logic tx,
  input logic cmd_rdy,
  input logic rd_vld
);

  // ====================
  // handshake rules
  // ====================

  a_rd_vld_single: assert property (@(posedge clk) disable iff (!rst_n) rd_vld |=> !rd_vld)
    else $error("rd_vld stayed high for more than one cycle");

  a_rd_vld_busy: assert property (@(posedge clk) disable iff (!rst_n) rd_vld |-> !cmd_rdy)
    else $error("rd_vld fired while the master was idle");

  // ====================
  // line rules
  // ====================

  a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else $error("tx low while the master was idle");  // no frame may be on the wire when idle

endmodule

bind uart_cmd_top uart_cmd_properties props_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .tx      (tx),
  .cmd_rdy (cmd_rdy),
  .rd_vld  (rd_vld)
);

/* verif/tb_uart_cmd.sv */
`timescale 1ns/1ps

module tb_uart_cmd;

  import uart_cmd_pkg::*;

  localparam int MAX_TESTS   = 16;
  localparam int REPLY_DELAY = 3 * CLKS_PER_BIT;  // remote turnaround counted from mid stop bit
  localparam int WAIT_LIMIT  = RESP_TIMEOUT + 4 * FRAME_BITS * CLKS_PER_BIT;

  logic        clk;
  logic        rst_n;
  logic        cmd_vld;
  cmd_word_t   cmd;
  logic        rx;
  logic        tx;
  logic        cmd_rdy;
  logic        rd_vld;
  rd_result_t  rd_result;
  logic [15:0] stim_mem [0:4*MAX_TESTS-1];
  int          err_cnt;
  int          test_cnt;
  int          fail_cnt;

  uart_cmd_top dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
    $display("Mismatch %s: got %h, expected %h", name, got, exp);
    err_cnt++;
  endtask

  task automatic report_error(input string what);
    $display("Error: %s", what);
    err_cnt++;
  endtask

  function automatic logic odd_parity_bit(input logic [7:0] b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++)
      ones += int'(b[i]);
    return (ones % 2) == 0;                       // makes the ones in data plus parity odd
  endfunction

  task automatic idle_cycles(input int count);
    repeat (count)
    begin
      @(negedge clk);
      if ({tx, cmd_rdy, rd_vld} !== 3'b110)
        report_mismatch("{tx,cmd_rdy,rd_vld}", 16'({tx, cmd_rdy, rd_vld}), 16'h6);
    end
  endtask

  // ====================
  // remote device, request side
  // ====================

  // entered half a cycle into the start bit and left at mid stop bit
  task automatic recv_frame(input string name, input logic [7:0] exp);
    logic [FRAME_BITS-1:0] bits;
    for (int k = 0; k < FRAME_BITS; k++)
    begin
      repeat ((k == 0) ? HALF_BIT : CLKS_PER_BIT) @(negedge clk);
      bits[k] = tx;
    end
    if (bits[0] !== 1'b0)
      report_error({name, " start bit did not last to mid-bit"});
    if (bits[8:1] !== exp)
      report_mismatch({name, " data"}, 16'(bits[8:1]), 16'(exp));
    if (bits[9] !== odd_parity_bit(bits[8:1]))
      report_mismatch({name, " parity"}, 16'(bits[9]), 16'(odd_parity_bit(bits[8:1])));
    if (bits[10] !== 1'b1)
      report_error({name, " stop bit was low"});
  endtask

  task automatic run_test(input logic [15:0] kind, input cmd_word_t word,
                          input logic [7:0] reply, input logic [1:0] mode);
    int                    err_start;
    int                    gap;
    int                    n;
    logic                  got;
    logic [FRAME_BITS-1:0] reply_bits;
    rd_result_t            exp;
    err_start = err_cnt;
    cmd       = word;
    cmd_vld   = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    if ({cmd_rdy, tx} !== 2'b00)
      report_mismatch("{cmd_rdy,tx}", 16'({cmd_rdy, tx}), 16'h0);
    recv_frame("frame 1", word.bytes.hi);
    if (kind == 16'd3)
    begin
      cmd     = ~word;
      cmd_vld = 1'b1;                             // offered while busy so it must be dropped
    end
    gap = 0;
    while (tx === 1'b1 && gap < WAIT_LIMIT)
    begin
      @(negedge clk);
      cmd_vld = 1'b0;
      gap++;
    end
    gap = gap - (CLKS_PER_BIT - HALF_BIT);        // from the end of the stop bit
    if (tx !== 1'b0)
      report_error("second request frame never started");
    else if (gap < GAP_CYCLES - 1 || gap > GAP_CYCLES + 1)
      report_mismatch("tx gap cycles", 16'(gap), 16'(GAP_CYCLES));
    recv_frame("frame 2", word.bytes.lo);
    n   = 0;
    got = 1'b0;
    if (word.fields.write)
    begin
      while (cmd_rdy !== 1'b1 && n < WAIT_LIMIT)
      begin
        @(negedge clk);
        n++;
        if (rd_vld === 1'b1)
          report_error("rd_vld fired for a write");
      end
      if (cmd_rdy !== 1'b1)
        report_error("cmd_rdy did not return after a write");
    end
    else
    begin
      reply_bits      = {mode != 2'd2, odd_parity_bit(reply) ^ (mode == 2'd1), reply, 1'b0};
      exp.data        = (mode == 2'd3) ? 8'h00 : reply;
      exp.parity_err  = (mode == 2'd1);
      exp.framing_err = (mode == 2'd2);
      exp.timeout     = (mode == 2'd3);
      while (!got && n < WAIT_LIMIT)
      begin
        @(negedge clk);
        if (rd_vld === 1'b1)
        begin
          got = 1'b1;
          if (rd_result !== exp)
            report_mismatch("rd_result", 16'(rd_result), 16'(exp));
        end
        if (mode != 2'd3 && n >= REPLY_DELAY && n < REPLY_DELAY + FRAME_BITS * CLKS_PER_BIT)
          rx = reply_bits[(n - REPLY_DELAY) / CLKS_PER_BIT];
        else
          rx = 1'b1;
        n++;
      end
      rx = 1'b1;
      if (!got)
        report_error("no rd_vld before the wait ran out");
      @(negedge clk);
      if ({rd_vld, cmd_rdy} !== 2'b01)
        report_mismatch("{rd_vld,cmd_rdy}", 16'({rd_vld, cmd_rdy}), 16'h1);
    end
    if (kind == 16'd3)
      idle_cycles(FRAME_BITS * CLKS_PER_BIT);     // the dropped word must not start a frame
    test_cnt++;
    if (err_cnt != err_start)
      fail_cnt++;
    $display("test %0d kind %0d cmd %h: %s", test_cnt, kind, word,
             (err_cnt == err_start) ? "passed" : "failed");
  endtask

  // ====================
  // main sequence
  // ====================

  initial
  begin
    cmd_vld  = 1'b0;
    cmd      = '0;
    rx       = 1'b1;
    rst_n    = 1'b0;
    err_cnt  = 0;
    test_cnt = 0;
    fail_cnt = 0;
    void'($urandom(55043));
    for (int i = 0; i < 4 * MAX_TESTS; i++)
      stim_mem[i] = '0;
    $readmemh("verif/uart_cmd_stim.txt", stim_mem);
    repeat (3) @(posedge clk);
    @(negedge clk);
    if ({tx, cmd_rdy, rd_vld} !== 3'b110)
      report_mismatch("{tx,cmd_rdy,rd_vld}", 16'({tx, cmd_rdy, rd_vld}), 16'h6);
    rst_n = 1'b1;
    idle_cycles(2 * CLKS_PER_BIT);
    test_cnt++;
    if (err_cnt != 0)
      fail_cnt++;
    $display("test %0d reset and idle line: %s", test_cnt, (err_cnt == 0) ? "passed" : "failed");
    for (int t = 0; t < MAX_TESTS && stim_mem[4*t] != 16'h0; t++)
    begin
      idle_cycles($urandom % 8);
      run_test(stim_mem[4*t], stim_mem[4*t+1], stim_mem[4*t+2][7:0], stim_mem[4*t+3][1:0]);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* verif/uart_cmd_stim.txt */
// kind (1 write, 2 read, 3 busy-drop), command word, reply byte, reply mode
// reply mode: 0 good, 1 bad parity, 2 bad stop, 3 silent; reply unused for writes
1 8a5c 00 0
1 ff00 00 0
2 1200 a7 0
2 7f00 00 0
2 2300 3c 1
2 4500 c3 2
2 0100 55 3
3 9e77 00 0
1 8001 00 0
3 3300 e1 0
2 5a00 ff 0

/* vlog.f */
src/uart_cmd_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_cmd_master.sv
src/uart_cmd_top.sv
verif/uart_cmd_properties.sv
verif/tb_uart_cmd.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_cmd \
  -f vlog.f -o sim_uart_cmd

out=$(./obj_dir/sim_uart_cmd) || true
echo "$out"

if echo "$out" | grep -q '^>>> PASS$'; then
  exit 0
fi
exit 1
